/* include/mcCtrl_cfg.svh */
`ifndef MC_CTRL_CFG_SVH
`define MC_CTRL_CFG_SVH

// instruction field widths
`define MC_OPCODE_W 6
`define MC_FUNCT_W 6
`define MC_SHAMT_W 5
`define MC_STATE_W 6

`define MC_OP_RTYPE 6'h00
`define MC_OP_J 6'h02
`define MC_OP_JAL 6'h03
`define MC_OP_BEQ 6'h04
`define MC_OP_BNE 6'h05
`define MC_OP_ADDIU 6'h09
`define MC_OP_LUI 6'h0f
`define MC_OP_LW 6'h23
`define MC_OP_SW 6'h2b

`define MC_FN_SLL 6'h00 // nop when shamt is zero
`define MC_FN_JR 6'h08
`define MC_FN_BREAK 6'h0d
`define MC_FN_ADD 6'h20
`define MC_FN_SUB 6'h22
`define MC_FN_AND 6'h24
`define MC_FN_XOR 6'h26
`define MC_FN_SLT 6'h2a

`define MC_ALU_LOAD 3'b000 // pass A
`define MC_ALU_ADD 3'b001
`define MC_ALU_SUB 3'b010
`define MC_ALU_AND 3'b011
`define MC_ALU_XOR 3'b110
`define MC_ALU_SLT 3'b111

`define MC_PC_SEQ 3'b000
`define MC_PC_BRANCH 3'b001
`define MC_PC_JUMP 3'b010
`define MC_PC_REG 3'b011

`define MC_WB_ALUOUT 3'b000
`define MC_WB_MDR 3'b001
`define MC_WB_IMM 3'b010 // lui result
`define MC_WB_FALSE 3'b011
`define MC_WB_TRUE 3'b100
`define MC_WB_PCLINK 3'b110

`endif

/* verilog/mcCtrlPkg.sv */
`default_nettype none

`include "mcCtrl_cfg.svh"

package mcCtrlPkg;

	typedef logic [`MC_OPCODE_W-1:0] opcode_t;
	typedef logic [`MC_FUNCT_W-1:0] funct_t;
	typedef logic [`MC_SHAMT_W-1:0] shamt_t;
	typedef logic [2:0] aluOp_t;
	typedef logic [2:0] pcSrc_t;
	typedef logic [2:0] wbSrc_t;
	typedef logic [1:0] aluBSrc_t;
	typedef logic [1:0] regDst_t;
	typedef logic [1:0] addrSrc_t;

	// codes 27..32 belonged to the shift states
	typedef enum logic [`MC_STATE_W-1:0] {
		Reset = 6'd0,
		MemoryRead = 6'd1,
		WaitMemoryRead = 6'd2,
		IRWrite = 6'd3,
		Decode = 6'd4,
		Add = 6'd5,
		And = 6'd6,
		Sub = 6'd7,
		Xor = 6'd8,
		Break = 6'd9,
		Nop = 6'd10,
		WriteRegAlu = 6'd11,
		Beq = 6'd12,
		Bne = 6'd13,
		Lw = 6'd14,
		LwStep2 = 6'd15,
		LwWait = 6'd16,
		LwStep4 = 6'd17,
		LwStep5 = 6'd18,
		Sw = 6'd19,
		SwStep2 = 6'd20,
		SwWait = 6'd21,
		Lui = 6'd22,
		J = 6'd23,
		Jr = 6'd24,
		WriteRegAluImm = 6'd25,
		Addiu = 6'd26,
		Slt = 6'd33,
		SltWrite = 6'd34,
		JalWriteLink = 6'd35,
		Jal = 6'd36
	} ctrlState_t;

	typedef enum logic [4:0] {
		AddOp, AndOp, SubOp, XorOp, BreakOp, NopOp, JrOp, SltOp,
		BeqOp, BneOp, LwOp, SwOp, LuiOp, JOp, JalOp, AddiuOp,
		Unsupported
	} instrClass_t;

endpackage

`default_nettype wire

/* verilog/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mcCtrl_cfg.svh"

module instrDecoder
	import mcCtrlPkg::*;
(
	input wire opcode_t opcode,
	input wire funct_t funct,
	input wire shamt_t shamt,
	output instrClass_t instrClass
);

	always_comb
	begin
		instrClass = Unsupported; // unlisted codes stall in Decode
		case (opcode)
			`MC_OP_RTYPE:
			begin
				case (funct)
					`MC_FN_ADD: instrClass = AddOp;
					`MC_FN_AND: instrClass = AndOp;
					`MC_FN_SUB: instrClass = SubOp;
					`MC_FN_XOR: instrClass = XorOp;
					`MC_FN_BREAK: instrClass = BreakOp;
					`MC_FN_JR: instrClass = JrOp;
					`MC_FN_SLT: instrClass = SltOp;
					`MC_FN_SLL:
					begin
						// only sll $0,$0,0 is kept, real shifts are gone
						if (shamt == '0)
						begin
							instrClass = NopOp;
						end
					end
					default:
					begin
						instrClass = Unsupported;
					end
				endcase
			end
			`MC_OP_BEQ: instrClass = BeqOp;
			`MC_OP_BNE: instrClass = BneOp;
			`MC_OP_LW: instrClass = LwOp;
			`MC_OP_SW: instrClass = SwOp;
			`MC_OP_LUI: instrClass = LuiOp;
			`MC_OP_J: instrClass = JOp;
			`MC_OP_JAL: instrClass = JalOp;
			`MC_OP_ADDIU: instrClass = AddiuOp;
			default:
			begin
				instrClass = Unsupported;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/stateSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module stateSequencer
	import mcCtrlPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire instrClass_t instrClass,
	output ctrlState_t state
);

	ctrlState_t nextState;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= Reset;
		end
		else
		begin
			state <= nextState;
		end
	end

	always_comb
	begin
		nextState = Reset;
		case (state)
			Reset: nextState = MemoryRead;
			MemoryRead: nextState = WaitMemoryRead;
			WaitMemoryRead: nextState = IRWrite;
			IRWrite: nextState = Decode;
			Decode:
			begin
				case (instrClass)
					AddOp: nextState = Add;
					AndOp: nextState = And;
					SubOp: nextState = Sub;
					XorOp: nextState = Xor;
					BreakOp: nextState = Break;
					NopOp: nextState = Nop;
					JrOp: nextState = Jr;
					SltOp: nextState = Slt;
					BeqOp: nextState = Beq;
					BneOp: nextState = Bne;
					LwOp: nextState = Lw;
					SwOp: nextState = Sw;
					LuiOp: nextState = Lui;
					JOp: nextState = J;
					JalOp: nextState = JalWriteLink;
					AddiuOp: nextState = Addiu;
					default: nextState = Decode; // unsupported, wait for reset
				endcase
			end
			Add, And, Sub, Xor: nextState = WriteRegAlu;
			WriteRegAlu: nextState = MemoryRead;
			Break: nextState = Break; // halt
			Nop, Beq, Bne, Lui, J, Jr: nextState = MemoryRead;
			Lw: nextState = LwStep2;
			LwStep2: nextState = LwWait;
			LwWait: nextState = LwStep4;
			LwStep4: nextState = LwStep5;
			LwStep5: nextState = MemoryRead;
			Sw: nextState = SwStep2;
			SwStep2: nextState = SwWait;
			SwWait: nextState = MemoryRead;
			Addiu: nextState = WriteRegAluImm;
			WriteRegAluImm: nextState = MemoryRead;
			Slt: nextState = SltWrite;
			SltWrite: nextState = MemoryRead;
			JalWriteLink: nextState = Jal;
			Jal: nextState = MemoryRead;
			default:
			begin
				nextState = Reset; // unused encodings
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/controlDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mcCtrl_cfg.svh"

module controlDecoder
	import mcCtrlPkg::*;
(
	input wire ctrlState_t state,
	input wire logic menor,
	output logic memWriteOrRead,
	output logic mdrControl,
	output logic pcControl,
	output logic pcCond,
	output logic bneOrBeq,
	output logic irWrite,
	output logic writeA,
	output logic writeB,
	output logic regWrite,
	output logic aluSrcA,
	output logic regAluControl,
	output pcSrc_t origPc,
	output aluBSrc_t aluSrcB,
	output aluOp_t aluControl,
	output regDst_t regDst,
	output wbSrc_t memToReg,
	output addrSrc_t iOrD
);

	always_comb
	begin
		// common word, each state overrides what differs
		memWriteOrRead = 1'b0;
		mdrControl = 1'b0;
		pcControl = 1'b0;
		pcCond = 1'b0;
		bneOrBeq = 1'b0;
		irWrite = 1'b0;
		writeA = 1'b1;
		writeB = 1'b1;
		regWrite = 1'b0;
		aluSrcA = 1'b1;
		regAluControl = 1'b0;
		origPc = `MC_PC_SEQ;
		aluSrcB = 2'b10; // sign-extended immediate
		aluControl = `MC_ALU_ADD;
		regDst = 2'b00;
		memToReg = `MC_WB_MDR;
		iOrD = 2'b01; // ALU result as address
		case (state)
			Reset:
			begin
				irWrite = 1'b1;
				aluControl = `MC_ALU_LOAD;
			end
			MemoryRead, WaitMemoryRead, IRWrite:
			begin
				iOrD = 2'b00; // fetch from PC
				aluSrcA = 1'b0;
				aluSrcB = 2'b01; // PC + 4
				irWrite = 1'b1;
				pcControl = (state == IRWrite);
			end
			Decode:
			begin
				aluSrcA = 1'b0;
				aluSrcB = 2'b11; // branch target precompute
				regAluControl = 1'b1;
			end
			Add, And, Sub, Xor:
			begin
				aluSrcB = 2'b00;
				writeA = 1'b0;
				writeB = 1'b0;
				regAluControl = 1'b1;
				case (state)
					And: aluControl = `MC_ALU_AND;
					Sub: aluControl = `MC_ALU_SUB;
					Xor: aluControl = `MC_ALU_XOR;
					default: aluControl = `MC_ALU_ADD;
				endcase
			end
			Break, Nop:
			begin
				memToReg = `MC_WB_ALUOUT;
				iOrD = 2'b00;
				aluControl = `MC_ALU_LOAD;
				aluSrcA = 1'b0;
				aluSrcB = 2'b00;
				writeA = 1'b0;
				writeB = 1'b0;
			end
			WriteRegAlu:
			begin
				irWrite = 1'b1;
				aluControl = `MC_ALU_LOAD;
				regDst = 2'b01; // rd
				regWrite = 1'b1;
				memToReg = `MC_WB_ALUOUT;
			end
			Beq, Bne:
			begin
				pcCond = 1'b1;
				origPc = `MC_PC_BRANCH;
				aluControl = `MC_ALU_SUB; // compare by subtraction
				aluSrcB = 2'b00;
				writeA = 1'b0;
				writeB = 1'b0;
				bneOrBeq = (state == Beq);
			end
			Lw, Sw:
			begin
				regAluControl = 1'b1; // latch effective address
				writeB = 1'b0;
			end
			LwStep2, LwWait:
			begin
				writeB = 1'b0;
			end
			LwStep4:
			begin
				mdrControl = 1'b1;
				writeB = 1'b0;
			end
			LwStep5:
			begin
				regWrite = 1'b1; // rt from MDR
				writeB = 1'b0;
			end
			SwStep2, SwWait:
			begin
				memWriteOrRead = 1'b1;
			end
			Lui:
			begin
				memToReg = `MC_WB_IMM;
				aluSrcA = 1'b0;
				aluSrcB = 2'b00;
				regWrite = 1'b1;
			end
			J, Jr:
			begin
				memToReg = `MC_WB_IMM;
				aluSrcA = 1'b0;
				aluSrcB = 2'b00;
				writeA = (state == Jr);
				writeB = 1'b0;
				pcControl = 1'b1;
				origPc = (state == Jr) ? `MC_PC_REG : `MC_PC_JUMP;
			end
			WriteRegAluImm:
			begin
				writeB = 1'b0;
				irWrite = 1'b1;
				aluControl = `MC_ALU_LOAD;
				regWrite = 1'b1; // rt
				memToReg = `MC_WB_ALUOUT;
			end
			Addiu:
			begin
				writeA = 1'b0;
				writeB = 1'b0;
				regAluControl = 1'b1;
			end
			Slt, SltWrite:
			begin
				aluControl = `MC_ALU_SLT;
				aluSrcB = 2'b00;
				memToReg = 3'b101; // don't care, no write yet
				if (state == SltWrite)
				begin
					regDst = 2'b01;
					regWrite = 1'b1;
					memToReg = menor ? `MC_WB_TRUE : `MC_WB_FALSE;
				end
			end
			JalWriteLink, Jal:
			begin
				aluSrcA = 1'b0;
				aluSrcB = 2'b00;
				writeA = 1'b0;
				writeB = 1'b0;
				origPc = `MC_PC_JUMP;
				memToReg = `MC_WB_IMM;
				pcControl = (state == Jal);
				if (state == JalWriteLink)
				begin
					memToReg = `MC_WB_PCLINK; // return address into $31
					aluControl = `MC_ALU_LOAD;
					regDst = 2'b10;
					regWrite = 1'b1;
				end
			end
			default:
			begin
				regWrite = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/multicycleControl.sv */
`timescale 1ns/10ps
`default_nettype none

module multicycleControl
	import mcCtrlPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire opcode_t opcode,
	input wire funct_t funct,
	input wire shamt_t shamt,
	input wire logic menor,
	output logic memWriteOrRead,
	output logic mdrControl,
	output logic pcControl,
	output logic pcCond,
	output logic bneOrBeq,
	output logic irWrite,
	output logic writeA,
	output logic writeB,
	output logic regWrite,
	output logic aluSrcA,
	output logic regAluControl,
	output pcSrc_t origPc,
	output aluBSrc_t aluSrcB,
	output aluOp_t aluControl,
	output regDst_t regDst,
	output wbSrc_t memToReg,
	output addrSrc_t iOrD,
	output ctrlState_t state
);

	instrClass_t instrClass;

	instrDecoder instrDecoder_i (
		.opcode(opcode),
		.funct(funct),
		.shamt(shamt),
		.instrClass(instrClass)
	);

	stateSequencer stateSequencer_i (
		.clk(clk),
		.reset(reset),
		.instrClass(instrClass),
		.state(state)
	);

	controlDecoder controlDecoder_i (
		.state(state),
		.menor(menor),
		.memWriteOrRead(memWriteOrRead),
		.mdrControl(mdrControl),
		.pcControl(pcControl),
		.pcCond(pcCond),
		.bneOrBeq(bneOrBeq),
		.irWrite(irWrite),
		.writeA(writeA),
		.writeB(writeB),
		.regWrite(regWrite),
		.aluSrcA(aluSrcA),
		.regAluControl(regAluControl),
		.origPc(origPc),
		.aluSrcB(aluSrcB),
		.aluControl(aluControl),
		.regDst(regDst),
		.memToReg(memToReg),
		.iOrD(iOrD)
	);

endmodule

`default_nettype wire

/* testbench/multicycleControl_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module multicycleControlAsserts
	import mcCtrlPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire ctrlState_t state,
	input wire logic memWriteOrRead,
	input wire logic regWrite
);

	logic inFetch;

	assign inFetch = (state == MemoryRead) || (state == WaitMemoryRead)
		|| (state == IRWrite) || (state == Decode);

	memWriteOnlyInSw: assert property (@(posedge clk) disable iff (reset)
		memWriteOrRead |-> ((state == SwStep2) || (state == SwWait)))
	else $error("memWriteOrRead high outside the sw write states");

	noRegWriteInFetch: assert property (@(posedge clk) disable iff (reset)
		inFetch |-> !regWrite)
	else $error("regWrite high during fetch or decode");

	breakHolds: assert property (@(posedge clk) disable iff (reset)
		(state == Break) |=> (state == Break)) // only reset leaves
	else $error("state left Break without a reset");

endmodule

bind multicycleControl multicycleControlAsserts multicycleControlAsserts_i (
	.clk(clk),
	.reset(reset),
	.state(state),
	.memWriteOrRead(memWriteOrRead),
	.regWrite(regWrite)
);

`default_nettype wire

/* testbench/multicycleControlTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mcCtrl_cfg.svh"

module multicycleControlTb
	import mcCtrlPkg::*;
();

	localparam int numInstr = 300;
	localparam int holdCycles = 6;
	localparam int timeoutCycles = numInstr * 10 + 1000;

	logic clk;
	logic reset;
	logic menor;
	opcode_t opcode;
	funct_t funct;
	shamt_t shamt;
	logic memWriteOrRead;
	logic mdrControl;
	logic pcControl;
	logic pcCond;
	logic bneOrBeq;
	logic irWrite;
	logic writeA;
	logic writeB;
	logic regWrite;
	logic aluSrcA;
	logic regAluControl;
	pcSrc_t origPc;
	aluBSrc_t aluSrcB;
	aluOp_t aluControl;
	regDst_t regDst;
	wbSrc_t memToReg;
	addrSrc_t iOrD;
	ctrlState_t state;

	int checkCount = 0;
	int errorCount = 0;
	int testChecks = 0;
	int testErrors = 0;
	ctrlState_t expQ[$]; // expected state per cycle

	multicycleControl dut_i (
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.funct(funct),
		.shamt(shamt),
		.menor(menor),
		.memWriteOrRead(memWriteOrRead),
		.mdrControl(mdrControl),
		.pcControl(pcControl),
		.pcCond(pcCond),
		.bneOrBeq(bneOrBeq),
		.irWrite(irWrite),
		.writeA(writeA),
		.writeB(writeB),
		.regWrite(regWrite),
		.aluSrcA(aluSrcA),
		.regAluControl(regAluControl),
		.origPc(origPc),
		.aluSrcB(aluSrcB),
		.aluControl(aluControl),
		.regDst(regDst),
		.memToReg(memToReg),
		.iOrD(iOrD),
		.state(state)
	);

	always #5 clk = ~clk;

	initial
	begin
		#(timeoutCycles * 10);
		$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checkCount++;
		testChecks++;
		if (got !== exp)
		begin
			errorCount++;
			testErrors++;
			$display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic checkOutputs(input ctrlState_t st, input logic mn);
		logic expRegW;
		expRegW = (st == WriteRegAlu) || (st == WriteRegAluImm) || (st == LwStep5)
			|| (st == Lui) || (st == SltWrite) || (st == JalWriteLink);
		checkValue("memWriteOrRead", memWriteOrRead, (st == SwStep2) || (st == SwWait));
		checkValue("mdrControl", mdrControl, st == LwStep4);
		checkValue("regWrite", regWrite, expRegW);
		checkValue("pcCond", pcCond, (st == Beq) || (st == Bne));
		checkValue("pcControl", pcControl,
			(st == IRWrite) || (st == J) || (st == Jr) || (st == Jal));
		case (st)
			Reset: checkValue("irWrite", irWrite, 1'b1);
			Beq, Bne:
			begin
				checkValue("origPc", origPc, `MC_PC_BRANCH);
				checkValue("bneOrBeq", bneOrBeq, st == Beq);
			end
			J, Jal: checkValue("origPc", origPc, `MC_PC_JUMP);
			Jr: checkValue("origPc", origPc, `MC_PC_REG);
			JalWriteLink:
			begin
				checkValue("regDst", regDst, 2'd2);
				checkValue("memToReg", memToReg, `MC_WB_PCLINK);
			end
			SltWrite:
			begin
				checkValue("regDst", regDst, 2'd1);
				checkValue("memToReg", memToReg, mn ? `MC_WB_TRUE : `MC_WB_FALSE);
			end
			Lw, LwStep2, LwWait, LwStep4, LwStep5, Sw, SwStep2, SwWait:
			begin
				checkValue("irWrite", irWrite, 1'b0); // memory ops leave IR alone
			end
			default:
			begin
			end
		endcase
		// ALU operation per state
		case (st)
			Add, Lw, Sw, Addiu: checkValue("aluControl", aluControl, `MC_ALU_ADD);
			Sub, Beq, Bne: checkValue("aluControl", aluControl, `MC_ALU_SUB);
			And: checkValue("aluControl", aluControl, `MC_ALU_AND);
			Xor: checkValue("aluControl", aluControl, `MC_ALU_XOR);
			Slt, SltWrite: checkValue("aluControl", aluControl, `MC_ALU_SLT);
			default:
			begin
			end
		endcase
		// operand, address and latch selects
		case (st)
			MemoryRead, WaitMemoryRead, IRWrite:
			begin
				checkValue("iOrD", iOrD, 2'b00); // PC addresses memory
				checkValue("aluSrcA", aluSrcA, 1'b0);
				checkValue("aluSrcB", aluSrcB, 2'b01); // PC + 4
			end
			Decode:
			begin
				checkValue("writeA", writeA, 1'b1); // register file into A and B
				checkValue("writeB", writeB, 1'b1);
			end
			Add, And, Sub, Xor:
			begin
				checkValue("aluSrcA", aluSrcA, 1'b1);
				checkValue("aluSrcB", aluSrcB, 2'b00);
				checkValue("regAluControl", regAluControl, 1'b1);
			end
			Lw, Sw, Addiu:
			begin
				checkValue("aluSrcB", aluSrcB, 2'b10); // immediate operand
				checkValue("regAluControl", regAluControl, 1'b1);
			end
			LwStep2, LwWait, SwStep2, SwWait:
			begin
				checkValue("iOrD", iOrD, 2'b01); // ALU result addresses memory
			end
			default:
			begin
			end
		endcase
	endtask

	// fetch, then the class chain from the cycle counts
	task automatic buildExpected(input instrClass_t cls, input int hold);
		expQ = {MemoryRead, WaitMemoryRead, IRWrite, Decode};
		case (cls)
			AddOp: expQ = {expQ, Add, WriteRegAlu};
			AndOp: expQ = {expQ, And, WriteRegAlu};
			SubOp: expQ = {expQ, Sub, WriteRegAlu};
			XorOp: expQ = {expQ, Xor, WriteRegAlu};
			SltOp: expQ = {expQ, Slt, SltWrite};
			AddiuOp: expQ = {expQ, Addiu, WriteRegAluImm};
			JalOp: expQ = {expQ, JalWriteLink, Jal};
			NopOp: expQ = {expQ, Nop};
			BeqOp: expQ = {expQ, Beq};
			BneOp: expQ = {expQ, Bne};
			LuiOp: expQ = {expQ, Lui};
			JOp: expQ = {expQ, J};
			JrOp: expQ = {expQ, Jr};
			SwOp: expQ = {expQ, Sw, SwStep2, SwWait};
			LwOp: expQ = {expQ, Lw, LwStep2, LwWait, LwStep4, LwStep5};
			BreakOp: repeat (hold) expQ.push_back(Break);
			default: repeat (hold) expQ.push_back(Decode); // stall
		endcase
	endtask

	// starts and ends on a falling edge, limit 0 walks the whole chain
	task automatic walkExpected(input opcode_t opc, input funct_t fn, input shamt_t sh,
		input logic mn, input int limit);
		int n;
		int i;
		n = ((limit > 0) && (limit < expQ.size())) ? limit : expQ.size();
		for (i = 0; i < n; i++)
		begin
			checkValue("state", state, expQ[i]);
			checkOutputs(expQ[i], mn);
			if (i == 0)
			begin
				opcode = opc; // held until the next instruction
				funct = fn;
				shamt = sh;
				menor = mn;
			end
			@(negedge clk);
		end
	endtask

	task automatic applyReset();
		reset = 1'b1;
		@(negedge clk);
		checkValue("state", state, Reset);
		checkOutputs(Reset, menor);
		@(negedge clk);
		checkValue("state", state, Reset);
		reset = 1'b0;
		@(negedge clk);
	endtask

	task automatic runInstr(input instrClass_t cls, input opcode_t opc, input funct_t fn,
		input shamt_t sh, input logic mn, input int hold);
		buildExpected(cls, hold);
		walkExpected(opc, fn, sh, mn, 0);
		if ((cls == BreakOp) || (cls == Unsupported))
		begin
			applyReset();
		end
	endtask

	function automatic logic isKnownOpcode(input opcode_t opc);
		case (opc)
			`MC_OP_RTYPE, `MC_OP_J, `MC_OP_JAL, `MC_OP_BEQ, `MC_OP_BNE,
			`MC_OP_ADDIU, `MC_OP_LUI, `MC_OP_LW, `MC_OP_SW: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic isKnownFunct(input funct_t fn);
		case (fn)
			`MC_FN_SLL, `MC_FN_JR, `MC_FN_BREAK, `MC_FN_ADD, `MC_FN_SUB,
			`MC_FN_AND, `MC_FN_XOR, `MC_FN_SLT: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic opcode_t opcodeOf(input instrClass_t cls);
		case (cls)
			BeqOp: return `MC_OP_BEQ;
			BneOp: return `MC_OP_BNE;
			LwOp: return `MC_OP_LW;
			SwOp: return `MC_OP_SW;
			LuiOp: return `MC_OP_LUI;
			JOp: return `MC_OP_J;
			JalOp: return `MC_OP_JAL;
			AddiuOp: return `MC_OP_ADDIU;
			default: return `MC_OP_RTYPE;
		endcase
	endfunction

	function automatic funct_t functOf(input instrClass_t cls, input funct_t other);
		case (cls)
			AddOp: return `MC_FN_ADD;
			AndOp: return `MC_FN_AND;
			SubOp: return `MC_FN_SUB;
			XorOp: return `MC_FN_XOR;
			BreakOp: return `MC_FN_BREAK;
			NopOp: return `MC_FN_SLL;
			JrOp: return `MC_FN_JR;
			SltOp: return `MC_FN_SLT;
			default: return other; // immediate bits for I and J types
		endcase
	endfunction

	task automatic drawInstr(output instrClass_t cls, output opcode_t opc,
		output funct_t fn, output shamt_t sh);
		int kind;
		fn = $urandom;
		sh = $urandom;
		if (($urandom % 100) < 4)
		begin
			cls = Unsupported;
			kind = $urandom % 3;
			opc = `MC_OP_RTYPE;
			if (kind == 0)
			begin
				do opc = $urandom; while (isKnownOpcode(opc));
			end
			else if (kind == 1)
			begin
				do fn = $urandom; while (isKnownFunct(fn));
			end
			else
			begin
				fn = `MC_FN_SLL;
				sh = ($urandom % 31) + 1; // real shift, now dropped
			end
		end
		else
		begin
			cls = instrClass_t'($urandom % 16);
			opc = opcodeOf(cls);
			fn = functOf(cls, fn);
			if (cls == NopOp)
			begin
				sh = '0;
			end
		end
	endtask

	task automatic reportTest(input string name);
		$display("test %s: %0d checks, %0d errors", name, testChecks, testErrors);
		testChecks = 0;
		testErrors = 0;
	endtask

	initial
	begin
		instrClass_t cls;
		opcode_t opc;
		funct_t fn;
		shamt_t sh;
		logic mn;
		clk = 1'b0;
		reset = 1'b1;
		menor = 1'b0;
		opcode = '0;
		funct = '0;
		shamt = '0;
		void'($urandom(32'h9b11575b));

		applyReset();
		runInstr(NopOp, `MC_OP_RTYPE, `MC_FN_SLL, '0, 1'b0, 0);
		reportTest("reset and fetch");

		repeat (numInstr)
		begin
			drawInstr(cls, opc, fn, sh);
			mn = $urandom % 2;
			runInstr(cls, opc, fn, sh, mn, holdCycles);
		end
		reportTest("random instruction stream");

		runInstr(Unsupported, 6'h3f, '0, '0, 1'b0, holdCycles);
		runInstr(Unsupported, `MC_OP_RTYPE, 6'h01, '0, 1'b0, holdCycles);
		runInstr(Unsupported, `MC_OP_RTYPE, `MC_FN_SLL, 5'd3, 1'b1, holdCycles);
		runInstr(BreakOp, `MC_OP_RTYPE, `MC_FN_BREAK, '0, 1'b0, 40);
		buildExpected(LwOp, 0);
		walkExpected(`MC_OP_LW, '0, '0, 1'b0, 6); // reset lands in LwWait
		applyReset();
		runInstr(AddOp, `MC_OP_RTYPE, `MC_FN_ADD, '0, 1'b0, 0);
		reportTest("halts and mid-run reset");

		$display("total: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TESTBENCH PASSED");
		end
		else
		begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* multicycleControl.f */
+incdir+include
verilog/mcCtrlPkg.sv
verilog/instrDecoder.sv
verilog/stateSequencer.sv
verilog/controlDecoder.sv
verilog/multicycleControl.sv
testbench/multicycleControl_asserts.sv
testbench/multicycleControlTb.sv
